// File: tests/map_tag_cases.txt
# Fields are hex. R = reset, C index valid src_tag dst_tag = table write
# B tag data port expect_data = beat (port 7 = dropped), E code = error check (0 none 1 dup 2 miss)
E 0
C 0 1 3 0
C 1 1 5 1
C 2 1 9 2
C 3 1 c 3
B 3 11110000 0 11110000
B 5 22220001 1 22220001
B 9 33330002 2 33330002
B c 44440003 3 44440003
B 5 55550004 1 55550004
B 5 55550005 1 55550005
B 3 66660006 0 66660006
E 0
B 7 deadbeef 7 0
E 2
B 9 77770007 2 77770007
B 8 0badf00d 7 0
E 2
B c 88880008 3 88880008
C 1 1 5 3
B 5 99990009 3 99990009
C 2 0 9 2
B 9 aaaa000a 7 0
B 3 bbbb000b 0 bbbb000b
E 2
R
E 0
C 0 1 a 1
C 2 1 a 2
E 1
B a cccc000c 2 cccc000c
C 1 1 6 0
B 6 dddd000d 0 dddd000d
B 4 eeee000e 7 0
E 1

// File: filelist.f
hw/fabric_pkg.sv
hw/fabric_map_cfg.sv
hw/fabric_map_tag.sv
hw/fabric_stream_buf.sv
hw/fabric_tag_demux.sv
hw/fabric_map_subsystem.sv
tests/tb_fabric_map_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the tag-mapping testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_fabric_map_subsystem -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation PASSED"
exit 0

// File: tests/tb_fabric_map_subsystem.sv
`timescale 1ns/1ps

module tb_fabric_map_subsystem;

  import fabric_pkg::*;

  // --------------------
  // DUT signals
  // --------------------

  logic                  clk;
  logic                  rst_n;
  logic                  cfg_we;
  logic [1:0]            cfg_index;
  map_entry_t            cfg_entry;
  logic                  in_valid;
  logic                  in_ready;
  in_beat_t              in_beat;
  logic [num_ports-1:0]  out_valid;
  logic [num_ports-1:0]  out_ready = '0;
  logic [data_width-1:0] out_data;
  logic                  error_valid;
  map_err_e              error_code;

  // Expected data per output port, oldest at the front
  logic [data_width-1:0] exp_q [num_ports][$];

  // Back-pressure generator state
  integer seed = 32'h164c_c616;

  // Command lines in the cases file, sizes the watchdog
  int case_count = 0;

  fabric_map_subsystem fabric_map_subsystem_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we      (cfg_we),
    .cfg_index   (cfg_index),
    .cfg_entry   (cfg_entry),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_beat     (in_beat),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data),
    .error_valid (error_valid),
    .error_code  (error_code)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // Checks
  // --------------------

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  // Port index travels in the tag field of the observed beat
  task automatic check_beat(input out_beat_t got);
    logic [data_width-1:0] want;
    if (exp_q[got.tag].size() == 0) begin
      fail_now($sformatf("ERROR at %0t: unexpected beat %h on port %0d",
                         $time, got.data, got.tag));
    end else begin
      want = exp_q[got.tag].pop_front();
      if (got.data !== want) begin
        fail_now($sformatf("ERROR at %0t: port %0d data %h, expected %h",
                           $time, got.tag, got.data, want));
      end
    end
  endtask

  // err_none means no error raised at all
  task automatic check_error(input map_err_e want);
    logic want_valid;
    want_valid = (want != err_none);
    if (error_valid !== want_valid || error_code !== want) begin
      fail_now($sformatf("ERROR at %0t: error_valid %b code %0d, expected %b code %0d",
                         $time, error_valid, error_code, want_valid, want));
    end
  endtask

  function automatic int pending_beats();
    int total;
    total = 0;
    for (int p = 0; p < num_ports; p++) begin
      total += exp_q[p].size();
    end
    return total;
  endfunction

  // New out_ready each falling edge, 75 percent high per port
  // Handshake for the coming rising edge is judged here, where everything is stable
  always @(negedge clk) begin
    out_beat_t got;
    for (int p = 0; p < num_ports; p++) begin
      out_ready[p] = (($random(seed) & 3) != 0);
    end
    for (int p = 0; p < num_ports; p++) begin
      if (out_valid[p] && out_ready[p]) begin
        got.tag  = p[out_tag_width-1:0];
        got.data = out_data;
        check_beat(got);
      end
    end
  end

  // --------------------
  // Stimulus tasks
  // --------------------

  // Every task starts and ends on a falling edge

  // Give the ports time to empty the buffer
  task automatic drain_outputs();
    int waited;
    waited = 0;
    while (pending_beats() != 0 && waited < 32) begin
      @(negedge clk);
      waited++;
    end
  endtask

  task automatic apply_reset();
    drain_outputs();
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic write_entry(input logic [1:0] idx, input logic vld,
                             input logic [in_tag_width-1:0] src,
                             input logic [out_tag_width-1:0] dst);
    cfg_we            = 1'b1;
    cfg_index         = idx;
    cfg_entry.valid   = vld;
    cfg_entry.src_tag = src;
    cfg_entry.dst_tag = dst;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  // Port 7 marks a beat that must be dropped
  task automatic send_beat(input logic [in_tag_width-1:0] tag,
                           input logic [data_width-1:0] data,
                           input logic [3:0] port, input logic [data_width-1:0] want);
    in_beat.tag  = tag;
    in_beat.data = data;
    in_valid     = 1'b1;
    if (port != 4'd7) begin
      exp_q[port[1:0]].push_back(want);
    end
    // in_ready follows the buffer fill level, steady between rising edges
    while (!in_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // --------------------
  // Cases file parsing
  // --------------------

  function automatic void skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != -1 && c != int'("\n")) begin
      c = $fgetc(fd);
    end
  endfunction

  // First command letter of the next line, skipping blanks and # comments
  function automatic int next_command(input int fd);
    int c;
    c = $fgetc(fd);
    while (c == int'(" ") || c == int'("\t") || c == int'("\n") ||
           c == int'("\r") || c == int'("#")) begin
      if (c == int'("#")) begin
        skip_line(fd);
      end
      c = $fgetc(fd);
    end
    return c;
  endfunction

  // Watchdog, 40 cycles for each command line
  initial begin
    wait (case_count > 0);
    repeat (case_count * 40) @(posedge clk);
    fail_now("Simulation timed out before all cases completed");
  end

  initial begin
    int          fd;
    int          cmd;
    int          n;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    rst_n     = 1'b0;
    cfg_we    = 1'b0;
    cfg_index = '0;
    cfg_entry = '0;
    in_valid  = 1'b0;
    in_beat   = '0;

    // Count the commands first
    fd = $fopen("tests/map_tag_cases.txt", "r");
    if (fd == 0) begin
      fail_now("Could not open tests/map_tag_cases.txt");
    end
    cmd = next_command(fd);
    while (cmd != -1) begin
      case_count++;
      skip_line(fd);
      cmd = next_command(fd);
    end
    $fclose(fd);

    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    fd = $fopen("tests/map_tag_cases.txt", "r");
    cmd = next_command(fd);
    while (cmd != -1) begin
      case (cmd)
        int'("R"): apply_reset();
        int'("C"): begin
          n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
          if (n != 4) begin
            fail_now("Malformed C line in cases file");
          end
          write_entry(f0[1:0], f1[0], f2[in_tag_width-1:0], f3[out_tag_width-1:0]);
        end
        int'("B"): begin
          n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
          if (n != 4) begin
            fail_now("Malformed B line in cases file");
          end
          send_beat(f0[in_tag_width-1:0], f1, f2[3:0], f3);
        end
        int'("E"): begin
          n = $fscanf(fd, "%h", f0);
          if (n != 1) begin
            fail_now("Malformed E line in cases file");
          end
          repeat (2) @(negedge clk);
          check_error(map_err_e'(f0[15:0]));
        end
        default: fail_now($sformatf("Unknown command %0d in cases file", cmd));
      endcase
      cmd = next_command(fd);
    end
    $fclose(fd);

    drain_outputs();
    if (pending_beats() != 0) begin
      fail_now($sformatf("Beats went missing, %0d expected beats never came out",
                         pending_beats()));
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// File: hw/fabric_map_subsystem.sv
`timescale 1ns/1ps

module fabric_map_subsystem (
  input  logic                              clk,
  input  logic                              rst_n,
  // Table write port
  input  logic                              cfg_we,
  input  logic [1:0]                        cfg_index,
  input  fabric_pkg::map_entry_t            cfg_entry,
  // Tagged input stream
  input  logic                              in_valid,
  output logic                              in_ready,
  input  fabric_pkg::in_beat_t              in_beat,
  // Output ports
  output logic [fabric_pkg::num_ports-1:0]  out_valid,
  input  logic [fabric_pkg::num_ports-1:0]  out_ready,
  output logic [fabric_pkg::data_width-1:0] out_data,
  // Sticky error report
  output logic                              error_valid,
  output fabric_pkg::map_err_e              error_code
);

  import fabric_pkg::*;

  // --------------------
  // Internal links
  // --------------------

  map_table_t map_table;

  // Lookup stage to buffer
  logic       tag_valid;
  logic       tag_ready;
  out_beat_t  tag_beat;

  // Buffer to port demux
  logic       buf_valid;
  logic       buf_ready;
  out_beat_t  buf_beat;

  fabric_map_cfg fabric_map_cfg_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_index (cfg_index),
    .cfg_entry (cfg_entry),
    .map_table (map_table)
  );

  fabric_map_tag fabric_map_tag_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_beat     (in_beat),
    .out_valid   (tag_valid),
    .out_ready   (tag_ready),
    .out_beat    (tag_beat),
    .map_table   (map_table),
    .error_valid (error_valid),
    .error_code  (error_code)
  );

  // Splits lookup from routing, one cycle of latency
  fabric_stream_buf fabric_stream_buf_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (tag_valid),
    .in_ready  (tag_ready),
    .in_beat   (tag_beat),
    .out_valid (buf_valid),
    .out_ready (buf_ready),
    .out_beat  (buf_beat)
  );

  fabric_tag_demux fabric_tag_demux_i (
    .in_valid  (buf_valid),
    .in_ready  (buf_ready),
    .in_beat   (buf_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

// File: hw/fabric_tag_demux.sv
`timescale 1ns/1ps

module fabric_tag_demux (
  // Buffered mapped stream
  input  logic                                in_valid,
  output logic                                in_ready,
  input  fabric_pkg::out_beat_t               in_beat,
  // Output ports sharing one data bus
  output logic [fabric_pkg::num_ports-1:0]    out_valid,
  input  logic [fabric_pkg::num_ports-1:0]    out_ready,
  output logic [fabric_pkg::data_width-1:0]   out_data
);

  import fabric_pkg::*;

  // --------------------
  // Port select
  // --------------------

  // Tag decodes to a one-hot valid, gated by the incoming valid
  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      out_valid[p] = in_valid && (in_beat.tag == p[out_tag_width-1:0]);
    end
  end

  // Only the selected port can stall the stream
  assign in_ready = out_ready[in_beat.tag];

  // Data is broadcast, valid tells each port whether it is theirs
  assign out_data = in_beat.data;

  // --------------------
  // Checks
  // --------------------

  // At most one port offered a beat at a time
  always_comb begin
    port_onehot: assert ($onehot0(out_valid))
      else $error("more than one out_valid bit high");
  end

endmodule

// File: hw/fabric_stream_buf.sv
`timescale 1ns/1ps

module fabric_stream_buf (
  input  logic                  clk,
  input  logic                  rst_n,
  // Write side
  input  logic                  in_valid,
  output logic                  in_ready,
  input  fabric_pkg::out_beat_t in_beat,
  // Read side
  output logic                  out_valid,
  input  logic                  out_ready,
  output fabric_pkg::out_beat_t out_beat
);

  import fabric_pkg::*;

  // --------------------
  // State
  // --------------------

  // Fill level 0..2
  logic [1:0] count;
  logic       wr_ptr;
  logic       rd_ptr;
  logic       push;
  logic       pop;

  // Two beat slots
  out_beat_t  slot_mem [2];

  // Both handshake flags come from the registered fill level only
  assign in_ready  = (count != 2'd2);
  assign out_valid = (count != 2'd0);
  assign out_beat  = slot_mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Pointers and fill level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count  <= 2'd0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop)  rd_ptr <= ~rd_ptr;
      // Simultaneous push and pop keeps the level
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  // Slot data
  always_ff @(posedge clk) begin
    if (push) begin
      slot_mem[wr_ptr] <= in_beat;
    end
  end

  // --------------------
  // Checks
  // --------------------

  no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n) (count == 2'd2) |-> !push
  ) else $error("push into full buffer");

  no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n) (count == 2'd0) |-> !pop
  ) else $error("pop from empty buffer");

endmodule

// File: hw/fabric_map_tag.sv
`timescale 1ns/1ps

module fabric_map_tag (
  input  logic                   clk,
  input  logic                   rst_n,
  // Tagged input stream
  input  logic                   in_valid,
  output logic                   in_ready,
  input  fabric_pkg::in_beat_t   in_beat,
  // Mapped stream towards the buffer
  output logic                   out_valid,
  input  logic                   out_ready,
  output fabric_pkg::out_beat_t  out_beat,
  // Current table contents
  input  fabric_pkg::map_table_t map_table,
  // First error, held until reset
  output logic                   error_valid,
  output fabric_pkg::map_err_e   error_code
);

  import fabric_pkg::*;

  // --------------------
  // CAM lookup
  // --------------------

  logic [table_size-1:0]    match_vec;
  logic                     match_found;
  logic [out_tag_width-1:0] matched_dst_tag;

  // Entry hits when valid and its source tag equals the beat tag
  always_comb begin
    for (int i = 0; i < table_size; i++) begin
      match_vec[i] = map_table[i].valid && (map_table[i].src_tag == in_beat.tag);
    end
  end

  assign match_found = |match_vec;

  // Ascending scan, so the highest matching index wins
  always_comb begin
    matched_dst_tag = '0;
    for (int i = 0; i < table_size; i++) begin
      if (match_vec[i]) begin
        matched_dst_tag = map_table[i].dst_tag;
      end
    end
  end

  // --------------------
  // Stream handshake
  // --------------------

  // Ready comes straight from the buffer and never looks at in_valid
  assign in_ready = out_ready;

  // Unmatched beats are taken but never forwarded
  assign out_valid = in_valid && match_found;

  // New tag, data untouched
  assign out_beat.tag  = matched_dst_tag;
  assign out_beat.data = in_beat.data;

  // --------------------
  // Error detection
  // --------------------

  logic cfg_dup_tag;
  logic rt_no_match;

  // Pairwise compare of valid entries
  always_comb begin
    cfg_dup_tag = 1'b0;
    for (int i = 0; i < table_size; i++) begin
      for (int j = i + 1; j < table_size; j++) begin
        if (map_table[i].valid && map_table[j].valid &&
            (map_table[i].src_tag == map_table[j].src_tag)) begin
          cfg_dup_tag = 1'b1;
        end
      end
    end
  end

  // Flagged on the edge that actually consumes the stray beat
  assign rt_no_match = in_valid && in_ready && !match_found;

  // Capture only while nothing is latched yet
  // Duplicate beats no-match when both show up together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code  <= err_none;
    end else if (!error_valid) begin
      if (cfg_dup_tag) begin
        error_valid <= 1'b1;
        error_code  <= cfg_map_tag_dup_tag;
      end else if (rt_no_match) begin
        error_valid <= 1'b1;
        error_code  <= rt_map_tag_no_match;
      end
    end
  end

  // Latched code stays put for as long as the error is raised
  error_code_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    error_valid |=> $stable(error_code)
  ) else $error("error_code changed while error_valid was high");

endmodule

// File: hw/fabric_map_cfg.sv
`timescale 1ns/1ps

module fabric_map_cfg (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cfg_we,
  input  logic [1:0]             cfg_index,
  input  fabric_pkg::map_entry_t cfg_entry,
  output fabric_pkg::map_table_t map_table
);

  import fabric_pkg::*;

  // --------------------
  // Write decode
  // --------------------

  // One strobe per slot
  logic [table_size-1:0] entry_we;

  always_comb begin
    for (int i = 0; i < table_size; i++) begin
      // Only the addressed slot sees the strobe
      entry_we[i] = cfg_we && (cfg_index == i[1:0]);
    end
  end

  // --------------------
  // Table storage
  // --------------------

  // All entries come out of reset invalid
  // New entry is visible to lookups on the cycle after the write edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      map_table <= '0;
    end else begin
      for (int i = 0; i < table_size; i++) begin
        if (entry_we[i]) begin
          // Whole entry replaced at once, valid bit included
          map_table[i] <= cfg_entry;
        end
      end
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Write attempted while the table is held in reset has unknown effect
  cfg_we_in_reset: assert property (
    @(posedge clk) !rst_n |-> !cfg_we
  ) else $error("cfg write during reset, result unknown");

endmodule

// File: hw/fabric_pkg.sv
package fabric_pkg;

  // --------------------
  // Stream widths
  // --------------------

  // Width of the data word carried by every beat
  localparam int data_width = 32;

  // Source tag arriving on the input stream
  localparam int in_tag_width = 4;

  // Destination tag, also the output port select
  localparam int out_tag_width = 2;

  // Number of entries in the mapping table
  localparam int table_size = 4;

  // One output port per destination tag value
  localparam int num_ports = 2 ** out_tag_width;

  // --------------------
  // Beats and table
  // --------------------

  // Beat on the input side, tag in the upper bits
  typedef struct packed {
    logic [in_tag_width-1:0] tag;
    logic [data_width-1:0]   data;
  } in_beat_t;

  // Beat after mapping
  typedef struct packed {
    logic [out_tag_width-1:0] tag;
    logic [data_width-1:0]    data;
  } out_beat_t;

  // Single table entry
  typedef struct packed {
    logic                     valid;
    logic [in_tag_width-1:0]  src_tag;
    logic [out_tag_width-1:0] dst_tag;
  } map_entry_t;

  // Whole table, entry 0 in the low bits
  typedef map_entry_t [table_size-1:0] map_table_t;

  // --------------------
  // Error codes
  // --------------------

  // Code reported with error_valid
  typedef enum logic [15:0] {
    err_none            = 16'd0,
    // Two valid entries share one src_tag
    cfg_map_tag_dup_tag = 16'd1,
    // Beat tag hit no valid entry
    rt_map_tag_no_match = 16'd2
  } map_err_e;

endpackage
